//--- tb.f
spi_pkg.sv
spi_bus_if.sv
spi_clk_gen.sv
spi_master.sv
spi_reg_slave.sv
spi_subsys_top.sv
tb_spi_subsys.sv

//--- tb_spi_subsys.sv
`timescale 1ns/10ps

module tb_spi_subsys;

    localparam int clk_div        = 2;
    localparam int max_transfers  = 87;
    localparam int timeout_cycles = max_transfers * (2 * clk_div * 8 + 4) + 200;

    logic       sys_clk = 1'b0;
    logic       rst_n;
    logic       t_start;
    logic [7:0] d_in;
    logic [3:0] t_size;
    logic [7:0] d_out;
    logic       done;
    logic       busy;

    logic [7:0]  model [16];  // expected register bank.
    logic [7:0]  frame_tx [32];
    logic [3:0]  frame_size [32];
    logic [7:0]  frame_rx [32];
    logic [31:0] rng         = 32'h6360f5a0;
    int          xfer_count  = 0;
    int          done_count  = 0;
    int          cycle_count = 0;
    int          poke_index  = -1;  // transfer that gets a stray t_start.

    spi_subsys_top #(
        .clk_div (clk_div)
    ) dut_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .t_start (t_start),
        .d_in    (d_in),
        .t_size  (t_size),
        .d_out   (d_out),
        .done    (done),
        .busy    (busy)
    );

    always #2 sys_clk = ~sys_clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        fail_run($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[15:8];
    endfunction

    function automatic logic [7:0] cmd_word(input logic rd, input int addr);
        spi_pkg::spi_word_u w;
        w.cmd.rw   = rd;
        w.cmd.addr = 7'(addr);
        return w.data;
    endfunction

    // one select frame; t_start goes high in each done cycle to chain.
    task automatic run_frame(input int n);
        int cyc;
        for (int i = 0; i < n; i++)
        begin
            t_start = 1'b1;
            d_in    = frame_tx[i];
            t_size  = frame_size[i];
            xfer_count++;
            @(negedge sys_clk);
            t_start = 1'b0;
            assert (busy && !dut_i.bus.cs_n)
            else fail_run("transfer was not accepted");
            assert (dut_i.bus.mosi == frame_tx[i][frame_size[i] - 1])
            else value_error("mosi", frame_tx[i][frame_size[i] - 1], dut_i.bus.mosi);
            cyc = 0;
            while (!done)
            begin
                assert (busy)
                else fail_run($sformatf("busy dropped before done, master in %s",
                                        dut_i.master_i.state.name()));
                t_start = (i == poke_index) && (cyc == 5);
                if (t_start)
                begin
                    d_in   = ~frame_tx[i];
                    t_size = 4'd8;
                end
                @(negedge sys_clk);
                cyc++;
            end
            t_start     = 1'b0;
            frame_rx[i] = d_out;  // taken in the done cycle.
        end
        repeat (2) @(negedge sys_clk);
        assert (!busy && dut_i.bus.cs_n)
        else fail_run("frame did not close after its last done");
        assert (done_count == xfer_count)
        else value_error("done count", xfer_count, done_count);
    endtask

    task automatic write_regs(input int addr, input int n);
        frame_tx[0]   = cmd_word(1'b0, addr);
        frame_size[0] = 4'd8;
        for (int j = 1; j <= n; j++)
        begin
            frame_tx[j]   = rand_byte();
            frame_size[j] = 4'd8;
        end
        run_frame(n + 1);
        for (int j = 0; j <= n; j++)
        begin
            assert (frame_rx[j] == 8'h00)  // miso quiet in a write frame.
            else value_error("d_out", 0, frame_rx[j]);
        end
        for (int j = 1; j <= n; j++)
        begin
            model[(addr + j - 1) % 16] = frame_tx[j];
        end
    endtask

    task automatic read_regs(input int addr, input int n);
        frame_tx[0]   = cmd_word(1'b1, addr);
        frame_size[0] = 4'd8;
        for (int j = 1; j <= n; j++)
        begin
            frame_tx[j]   = rand_byte();  // must not be written.
            frame_size[j] = 4'd8;
        end
        run_frame(n + 1);
        assert (frame_rx[0] == 8'h00)
        else value_error("d_out", 0, frame_rx[0]);
        for (int j = 1; j <= n; j++)
        begin
            assert (frame_rx[j] == model[(addr + j - 1) % 16])
            else value_error($sformatf("d_out reg %0d", (addr + j - 1) % 16),
                             model[(addr + j - 1) % 16], frame_rx[j]);
        end
    endtask

    task automatic read_partial(input int addr, input int k);
        frame_tx[0]   = cmd_word(1'b1, addr);
        frame_size[0] = 4'd8;
        frame_tx[1]   = rand_byte();
        frame_size[1] = 4'(k);
        run_frame(2);
        assert (frame_rx[1] == (model[addr] >> (8 - k)))
        else value_error($sformatf("d_out k=%0d", k), model[addr] >> (8 - k), frame_rx[1]);
    endtask

    task automatic try_bad_size(input logic [3:0] size);
        t_start = 1'b1;
        t_size  = size;
        d_in    = rand_byte();
        @(negedge sys_clk);
        t_start = 1'b0;
        repeat (6)
        begin
            assert (!busy && !done && dut_i.bus.cs_n)
            else fail_run($sformatf("t_start with t_size %0d was not ignored", size));
            @(negedge sys_clk);
        end
        assert (done_count == xfer_count)
        else value_error("done count", xfer_count, done_count);
    endtask

    done_single: assert property (@(posedge sys_clk) disable iff (!rst_n) done |=> !done)
    else fail_run("done stayed high for more than one cycle");

    done_in_busy: assert property (@(posedge sys_clk) disable iff (!rst_n) done |-> busy)
    else fail_run("done pulsed while busy was low");

    cs_follows_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
                                      dut_i.bus.cs_n == !busy)
    else fail_run("cs_n and busy disagree");

    sclk_parked: assert property (@(posedge sys_clk) disable iff (!rst_n)
                                  !busy |-> !dut_i.bus.sclk)
    else fail_run("sclk toggled outside a transfer");

    miso_quiet: assert property (@(posedge sys_clk) disable iff (!rst_n)
                                 dut_i.bus.cs_n |-> !dut_i.bus.miso)
    else fail_run("miso driven while cs_n was high");

    always @(negedge sys_clk)
    begin
        if (done)
        begin
            done_count++;
        end
    end

    always @(posedge sys_clk)
    begin
        cycle_count++;
        if (cycle_count > timeout_cycles)
        begin
            $display("timeout after %0d cycles, master in state %s", cycle_count,
                     dut_i.master_i.state.name());
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial
    begin
        int a;
        int n;
        int addr;
        rst_n   = 1'b0;
        t_start = 1'b0;
        d_in    = '0;
        t_size  = '0;
        for (int i = 0; i < 16; i++)
        begin
            model[i] = '0;
        end
        repeat (2) @(negedge sys_clk);
        rst_n = 1'b1;
        @(negedge sys_clk);
        assert (!busy && !done && d_out == 8'h00 && dut_i.bus.cs_n && !dut_i.bus.sclk)
        else fail_run("outputs not at their reset values");

        read_regs(0, 16);

        // burst write and read back.
        a = rand_byte() % 16;
        write_regs(a, 3);
        read_regs(a, 3);

        write_regs(15, 2);  // second byte lands at 0.
        read_regs(15, 2);

        for (int k = 1; k < 8; k++)
        begin
            read_partial(a, k);
        end

        try_bad_size(4'd0);
        try_bad_size(4'd9);
        poke_index = 1;
        read_regs((a + 1) % 16, 1);
        poke_index = -1;

        repeat (4)
        begin
            n    = 1 + rand_byte() % 4;
            addr = rand_byte() % 16;
            write_regs(addr, n);
            read_regs(addr, n);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- spi_subsys_top.sv
`timescale 1ns/10ps

module spi_subsys_top #(
    parameter int clk_div = 2
) (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       t_start,
    input  logic [7:0] d_in,
    input  logic [3:0] t_size,
    output logic [7:0] d_out,
    output logic       done,
    output logic       busy
);

    logic sclk_en;
    logic sclk;
    logic sclk_rise;
    logic sclk_fall;

    spi_bus_if bus ();

    spi_clk_gen #(
        .clk_div (clk_div)
    ) clk_gen_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .en        (sclk_en),
        .sclk      (sclk),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    spi_master #(
        .reg_width (spi_pkg::word_width)
    ) master_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .t_start   (t_start),
        .d_in      (d_in),
        .t_size    (t_size),
        .d_out     (d_out),
        .done      (done),
        .busy      (busy),
        .sclk_en   (sclk_en),
        .sclk      (sclk),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .bus       (bus.master)
    );

    spi_reg_slave slave_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .bus     (bus.slave)
    );

endmodule

//--- spi_reg_slave.sv
`timescale 1ns/10ps

module spi_reg_slave (
    input  logic     sys_clk,
    input  logic     rst_n,
    spi_bus_if.slave bus
);

    localparam int bit_width = $clog2(spi_pkg::word_width);

    logic [spi_pkg::word_width-1:0] regs [spi_pkg::reg_count];

    logic                           sclk_q;
    logic                           cs_q;
    logic                           sclk_rise;
    logic                           sclk_fall;
    logic                           cs_rise;
    logic [bit_width-1:0]           bit_cnt;
    logic [1:0]                     byte_cnt;
    logic                           rd_mode;
    logic [spi_pkg::addr_width-1:0] addr;
    logic [spi_pkg::addr_width-1:0] cmd_addr;
    logic [spi_pkg::word_width-2:0] rx_sr;
    logic [spi_pkg::word_width-1:0] tx_sr;
    logic                           miso_q;
    logic                           byte_end;
    logic                           cmd_byte;
    spi_pkg::spi_word_u             rx_word;

    // bus levels are already sys_clk aligned, one register is enough for edges.
    assign sclk_rise = bus.sclk & ~sclk_q;
    assign sclk_fall = ~bus.sclk & sclk_q;
    assign cs_rise   = bus.cs_n & ~cs_q;

    assign rx_word  = {rx_sr, bus.mosi};  // full byte as it completes.
    assign byte_end = sclk_rise && !bus.cs_n && (bit_cnt == '1);
    assign cmd_byte = (byte_cnt == '0);
    assign cmd_addr = rx_word.cmd.addr[spi_pkg::addr_width-1:0];

    assign bus.miso = miso_q & ~bus.cs_n;

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sclk_q <= 1'b0;
            cs_q   <= 1'b1;
        end
        else
        begin
            sclk_q <= bus.sclk;
            cs_q   <= bus.cs_n;
        end
    end

    // frame position, command decode and address.
    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rd_mode  <= 1'b0;
            addr     <= '0;
        end
        else if (cs_rise)
        begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rd_mode  <= 1'b0;
        end
        else if (sclk_rise && !bus.cs_n)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            if (byte_end)
            begin
                if (byte_cnt != '1)
                begin
                    byte_cnt <= byte_cnt + 1'b1;  // saturates, only the first byte matters.
                end
                if (cmd_byte)
                begin
                    rd_mode <= rx_word.cmd.rw;
                    addr    <= cmd_addr;
                end
                else
                begin
                    addr <= addr + 1'b1;  // wraps at the end of the bank.
                end
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (sclk_rise)
        begin
            rx_sr <= rx_word.data[spi_pkg::word_width-2:0];
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < spi_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (byte_end && !cmd_byte && !rd_mode)
        begin
            regs[addr] <= rx_word.data;
        end
    end

    // read data; the next register is fetched as each byte completes.
    always_ff @(posedge sys_clk)
    begin
        if (byte_end && cmd_byte)
        begin
            tx_sr <= regs[cmd_addr];
        end
        else if (byte_end)
        begin
            tx_sr <= regs[addr + 1'b1];
        end
        else if (sclk_fall)
        begin
            tx_sr <= {tx_sr[spi_pkg::word_width-2:0], 1'b0};
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            miso_q <= 1'b0;
        end
        else if (bus.cs_n)
        begin
            miso_q <= 1'b0;
        end
        else if (sclk_fall)
        begin
            miso_q <= rd_mode & tx_sr[spi_pkg::word_width-1];  // quiet during writes.
        end
    end

endmodule

//--- spi_master.sv
`timescale 1ns/10ps

module spi_master #(
    parameter int reg_width = 8
) (
    input  logic                       sys_clk,
    input  logic                       rst_n,
    input  logic                       t_start,
    input  logic [reg_width-1:0]       d_in,
    input  logic [$clog2(reg_width):0] t_size,
    output logic [reg_width-1:0]       d_out,
    output logic                       done,
    output logic                       busy,
    output logic                       sclk_en,
    input  logic                       sclk,
    input  logic                       sclk_rise,
    input  logic                       sclk_fall,
    spi_bus_if.master                  bus
);

    localparam int cnt_width = $clog2(reg_width) + 1;

    spi_pkg::master_state_t state;

    logic [cnt_width-1:0] bit_cnt;
    logic [reg_width-1:0] tx_sr;
    logic [reg_width-1:0] rx_sr;
    logic                 cs_n;
    logic                 size_ok;
    logic                 accept;
    logic                 last_fall;

    assign size_ok = (t_size != '0) && (t_size <= reg_width);

    // a new transfer may start from idle or straight out of unload.
    assign accept = t_start && size_ok &&
                    ((state == spi_pkg::idle) || (state == spi_pkg::unload));

    assign last_fall = (state == spi_pkg::transact) && sclk_fall && (bit_cnt == 1);

    // drop the enable on the last fall, else clk_div of 1 would start another rise.
    assign sclk_en = (state == spi_pkg::load) ||
                     ((state == spi_pkg::transact) && !last_fall);

    assign bus.sclk = sclk;
    assign bus.cs_n = cs_n;
    assign bus.mosi = tx_sr[reg_width-1] & ~cs_n;

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= spi_pkg::idle;
            bit_cnt <= '0;
            cs_n    <= 1'b1;
            busy    <= 1'b0;
            done    <= 1'b0;
            d_out   <= '0;
        end
        else
        begin
            case (state)
                spi_pkg::idle:
                begin
                    if (accept)
                    begin
                        state   <= spi_pkg::load;
                        bit_cnt <= t_size;
                        cs_n    <= 1'b0;
                        busy    <= 1'b1;
                    end
                end
                spi_pkg::load:
                begin
                    state <= spi_pkg::transact;  // clock generator runs from here.
                end
                spi_pkg::transact:
                begin
                    if (sclk_fall)
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == 1)
                        begin
                            state <= spi_pkg::unload;
                            done  <= 1'b1;
                            d_out <= rx_sr;  // already right-aligned.
                        end
                    end
                end
                spi_pkg::unload:
                begin
                    done <= 1'b0;
                    if (accept)
                    begin
                        // keep the frame open.
                        state   <= spi_pkg::load;
                        bit_cnt <= t_size;
                    end
                    else
                    begin
                        state <= spi_pkg::idle;
                        cs_n  <= 1'b1;
                        busy  <= 1'b0;
                    end
                end
                default:
                begin
                    state <= spi_pkg::idle;
                end
            endcase
        end
    end

    // shift registers.
    always_ff @(posedge sys_clk)
    begin
        if (accept)
        begin
            tx_sr <= d_in << (reg_width - t_size);  // low t_size bits go out first.
            rx_sr <= '0;
        end
        else if (state == spi_pkg::transact)
        begin
            if (sclk_rise)
            begin
                rx_sr <= {rx_sr[reg_width-2:0], bus.miso};
            end
            if (sclk_fall)
            begin
                tx_sr <= {tx_sr[reg_width-2:0], 1'b0};
            end
        end
    end

endmodule

//--- spi_clk_gen.sv
`timescale 1ns/10ps

module spi_clk_gen #(
    parameter int clk_div = 2
) (
    input  logic sys_clk,
    input  logic rst_n,
    input  logic en,
    output logic sclk,
    output logic sclk_rise,
    output logic sclk_fall
);

    localparam int cnt_width = (clk_div > 1) ? $clog2(clk_div) : 1;

    logic [cnt_width-1:0] half_cnt;
    logic                 half_end;

    assign half_end = (half_cnt == cnt_width'(clk_div - 1));

    // strobes are registered alongside sclk so they line up with the level.
    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            half_cnt  <= '0;
            sclk      <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end
        else if (!en)
        begin
            half_cnt  <= '0;  // park low, ready for a fresh low half.
            sclk      <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end
        else if (half_end)
        begin
            half_cnt  <= '0;
            sclk      <= ~sclk;
            sclk_rise <= ~sclk;
            sclk_fall <= sclk;
        end
        else
        begin
            half_cnt  <= half_cnt + 1'b1;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end
    end

endmodule

//--- spi_bus_if.sv
`timescale 1ns/10ps

interface spi_bus_if;

    logic sclk;
    logic mosi;
    logic miso;
    logic cs_n;

    modport master (
        output sclk,
        output mosi,
        output cs_n,
        input  miso
    );

    modport slave (
        input  sclk,
        input  mosi,
        input  cs_n,
        output miso
    );

endinterface

//--- spi_pkg.sv
package spi_pkg;

    // one spi word and the register bank behind the peripheral.
    localparam int word_width = 8;
    localparam int reg_count  = 16;
    localparam int addr_width = $clog2(reg_count);

    // first byte of a frame.
    typedef struct packed {
        logic                  rw;    // 1 means read.
        logic [word_width-2:0] addr;  // only the low addr_width bits decode.
    } spi_cmd_t;

    // a received byte is a command or plain data depending on its position.
    typedef union packed {
        spi_cmd_t              cmd;
        logic [word_width-1:0] data;
    } spi_word_u;

    typedef enum logic [1:0] {
        idle,
        load,
        transact,
        unload
    } master_state_t;

endpackage
